//--- compile.f
+incdir+hw
hw/sys_glue_pkg.sv
hw/frame_counter.sv
hw/reset_sequencer.sv
hw/address_decoder.sv
hw/cpu_bus_port.sv
hw/sys_glue_top.sv
tb/tb_clock_gen.sv
tb/sys_glue_tb.sv

//--- run.sh
#!/bin/sh
# build and run the system glue testbench with verilator
# exit status is 0 only when sim.log holds the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module sys_glue_tb -f compile.f -o sys_glue_sim \
	&& ./obj_dir/sys_glue_sim > sim.log 2>&1 \
	|| { echo "build or simulation failed, see sim.log"; exit 1; }

grep -qx "TEST RESULT: PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

//--- tb/sys_glue_tb.sv
//----------------------------------------------------------
// testbench for the system glue top level
// rows are queued at time 0 and applied in order
// sof rows expect the sequencer to sit in COUNT
// outputs are sampled on the falling clock edge
//----------------------------------------------------------
`timescale 1ns/1ps
`include "sys_glue_macros.svh"

module sys_glue_tb;

	import sys_glue_pkg::*;

	localparam int HOLD_CYCLES = 3; // stall length on back-pressure rows

	typedef struct {
		bit         usr_reset; // row pulses usr_reset only
		bit         sof; // row pulses sof only
		cpu_addr_t  addr;
		bit         write;
		data_word_t wdata;
		data_word_t ext; // ext_rdata during the access
		bit         freeze;
		ipl_t       ipl_n;
		bit         resp_ready;
		region_t    exp_region;
		data_word_t exp_data;
	} row_t;

	logic clk;
	logic reset;
	logic usr_reset;
	logic sof;
	logic req_valid;
	logic req_ready;
	cpu_addr_t req_addr;
	logic req_write;
	data_word_t req_wdata;
	data_word_t ext_rdata;
	logic [63:0] rtc;
	logic resp_valid;
	logic resp_ready;
	region_t resp_region;
	data_word_t resp_data;
	ipl_t ipl_n_in;
	logic freeze;
	ipl_t ipl_n_out;
	logic sys_reset;
	logic cpu_reset_n;

	row_t rows[$];
	logic [31:0] lcg_state;
	int mismatch_count = 0;
	int fail_count = 0;
	int sof_seen = 0; // pulses since the last reset
	int cycle_count = 0;
	int cycle_limit = 1000;

	tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(3)) clock_gen_i (
		.clk   (clk),
		.reset (reset)
	);

	sys_glue_top dut_i (
		.clk         (clk),
		.reset       (reset),
		.usr_reset   (usr_reset),
		.sof         (sof),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.req_addr    (req_addr),
		.req_write   (req_write),
		.req_wdata   (req_wdata),
		.ext_rdata   (ext_rdata),
		.rtc         (rtc),
		.resp_valid  (resp_valid),
		.resp_ready  (resp_ready),
		.resp_region (resp_region),
		.resp_data   (resp_data),
		.ipl_n_in    (ipl_n_in),
		.freeze      (freeze),
		.ipl_n_out   (ipl_n_out),
		.sys_reset   (sys_reset),
		.cpu_reset_n (cpu_reset_n)
	);

	//----------------------------------------------------------
	// stimulus helpers
	//----------------------------------------------------------
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// writes answer zero, rtc reads give the nibble at address bits 5..2
	function automatic data_word_t expected_data(input row_t r);
		if (r.write) return '0;
		if (r.exp_region == REGION_RTC) begin
			return data_word_t'((rtc >> (4 * r.addr[4:1])) & 64'hF);
		end
		return r.ext;
	endfunction

	task automatic push_access(input logic [7:0] bank, input logic [3:0] nib, input bit write,
			input bit frz, input bit rdy, input region_t region);
		row_t r;
		logic [31:0] rnd;
		rnd = next_random();
		r.usr_reset = 1'b0;
		r.sof = 1'b0;
		r.addr = {bank, 10'd0, nib, 1'b0}; // nib lands on address bits 5..2
		r.write = write;
		r.ext = rnd[31:16];
		r.wdata = rnd[15:0];
		rnd = next_random();
		r.ipl_n = rnd[31:29];
		r.freeze = frz;
		r.resp_ready = rdy;
		r.exp_region = region;
		r.exp_data = expected_data(r);
		rows.push_back(r);
	endtask

	task automatic add_event(input bit usr, input bit pulse);
		row_t r;
		r.usr_reset = usr;
		r.sof = pulse;
		rows.push_back(r);
	endtask

	task automatic build_table();
		repeat (`RESET_FRAMES) add_event(1'b0, 1'b1);
		push_access(8'h00, 4'h0, 1'b0, 1'b0, 1'b1, REGION_KICK); // overlay still on
		push_access(8'hF8, 4'h1, 1'b0, 1'b0, 1'b1, REGION_KICK);
		push_access(8'h10, 4'h2, 1'b0, 1'b0, 1'b1, REGION_CHIP); // above overlay window
		push_access(8'hBF, 4'h0, 1'b1, 1'b0, 1'b1, REGION_CIA_A); // clears overlay
		push_access(8'h00, 4'h0, 1'b0, 1'b0, 1'b1, REGION_CHIP);
		push_access(8'hF8, 4'h4, 1'b0, 1'b0, 1'b1, REGION_KICK);
		push_access(8'h05, 4'h6, 1'b0, 1'b0, 1'b1, REGION_CHIP);
		push_access(8'hDC, 4'h0, 1'b0, 1'b0, 1'b1, REGION_RTC);
		push_access(8'hDC, 4'h3, 1'b0, 1'b0, 1'b1, REGION_RTC);
		push_access(8'hDC, 4'h9, 1'b0, 1'b0, 1'b1, REGION_RTC);
		push_access(8'hDC, 4'hF, 1'b0, 1'b0, 1'b1, REGION_RTC);
		push_access(8'hDC, 4'h5, 1'b1, 1'b0, 1'b1, REGION_RTC); // write, zero data
		push_access(8'h40, 4'h0, 1'b0, 1'b0, 1'b1, REGION_NONE);
		push_access(8'hC0, 4'h8, 1'b0, 1'b0, 1'b1, REGION_NONE);
		push_access(8'h00, 4'h2, 1'b1, 1'b0, 1'b1, REGION_CHIP);
		push_access(8'h1F, 4'h0, 1'b0, 1'b1, 1'b1, REGION_CHIP); // freeze forces level 7
		push_access(8'hBF, 4'h1, 1'b0, 1'b0, 1'b1, REGION_CIA_A);
		push_access(8'hDC, 4'h7, 1'b0, 1'b0, 1'b0, REGION_RTC); // stalled response
		push_access(8'h20, 4'h0, 1'b0, 1'b0, 1'b0, REGION_NONE);
		add_event(1'b1, 1'b0);
		repeat (`RESET_FRAMES) add_event(1'b0, 1'b1);
		push_access(8'h00, 4'h0, 1'b0, 1'b0, 1'b1, REGION_KICK); // overlay back on
		push_access(8'hBF, 4'h2, 1'b1, 1'b0, 1'b1, REGION_CIA_A);
		push_access(8'h00, 4'h0, 1'b0, 1'b0, 1'b1, REGION_CHIP);
	endtask

	//----------------------------------------------------------
	// checks and row execution
	//----------------------------------------------------------
	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else begin
			mismatch_count++;
			$display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic apply_sof();
		@(posedge clk);
		sof <= 1'b1;
		@(posedge clk);
		sof <= 1'b0;
		sof_seen++;
		@(negedge clk);
		check_value("sys_reset", sys_reset, 1'b1); // counter only just reached the pulse
		check_value("req_ready", req_ready, 1'b0);
		check_value("resp_valid", resp_valid, 1'b0);
		if (sof_seen == `RESET_FRAMES) begin
			while (sys_reset) @(negedge clk); // release latency is not fixed
			check_value("cpu_reset_n", cpu_reset_n, 1'b0);
			check_value("req_ready", req_ready, 1'b1);
			@(negedge clk);
			check_value("cpu_reset_n", cpu_reset_n, 1'b0);
			@(negedge clk);
			check_value("cpu_reset_n", cpu_reset_n, 1'b1); // two cycles after the fall
		end
	endtask

	task automatic pulse_user_reset();
		@(posedge clk);
		usr_reset <= 1'b1;
		@(posedge clk);
		usr_reset <= 1'b0;
		sof_seen = 0;
		@(negedge clk);
		check_value("sys_reset", sys_reset, 1'b1);
		check_value("req_ready", req_ready, 1'b0);
	endtask

	task automatic perform_access(input row_t r);
		region_t held_region;
		data_word_t held_data;
		@(posedge clk);
		req_valid  <= 1'b1;
		req_addr   <= r.addr;
		req_write  <= r.write;
		req_wdata  <= r.wdata;
		ext_rdata  <= r.ext;
		freeze     <= r.freeze;
		ipl_n_in   <= r.ipl_n;
		resp_ready <= r.resp_ready;
		@(negedge clk);
		while (!req_ready) @(negedge clk); // cycle limit catches a port that never opens
		@(posedge clk); // accepting edge
		req_valid <= 1'b0;
		@(negedge clk);
		check_value("resp_valid", resp_valid, 1'b1);
		check_value("resp_region", resp_region, r.exp_region);
		check_value("resp_data", resp_data, r.exp_data);
		check_value("ipl_n_out", ipl_n_out, r.freeze ? 3'b000 : r.ipl_n);
		held_region = resp_region;
		held_data = resp_data;
		if (!r.resp_ready) begin
			@(posedge clk);
			req_valid <= 1'b1; // second request presses on the stalled port
			ext_rdata <= ~r.ext;
			repeat (HOLD_CYCLES) begin
				@(negedge clk);
				check_value("req_ready", req_ready, 1'b0);
				check_value("resp_valid", resp_valid, 1'b1);
				check_value("resp_region", resp_region, held_region);
				check_value("resp_data", resp_data, held_data);
			end
			@(posedge clk);
			req_valid  <= 1'b0;
			resp_ready <= 1'b1;
			@(negedge clk);
			check_value("resp_valid", resp_valid, 1'b1); // taken on the next edge
		end
		@(negedge clk);
		check_value("resp_valid", resp_valid, 1'b0); // exactly one response consumed
	endtask

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	endtask

	// run limit from the table length
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run still busy after %0d cycles", cycle_count);
			fail_count++;
			finish_run();
		end
	end

	//----------------------------------------------------------
	// main sequence
	//----------------------------------------------------------
	initial begin
		lcg_state  = 32'd8988;
		usr_reset  = 1'b0;
		sof        = 1'b0;
		req_valid  = 1'b0;
		req_addr   = '0;
		req_write  = 1'b0;
		req_wdata  = '0;
		ext_rdata  = '0;
		freeze     = 1'b0;
		ipl_n_in   = 3'b111;
		resp_ready = 1'b1;
		rtc[31:0]  = next_random();
		rtc[63:32] = next_random(); // fixed for the whole run
		build_table();
		cycle_limit = 2 * rows.size() + 200;
		@(negedge clk);
		while (reset) @(negedge clk);
		check_value("sys_reset", sys_reset, 1'b1);
		check_value("cpu_reset_n", cpu_reset_n, 1'b0);
		check_value("req_ready", req_ready, 1'b0);
		check_value("resp_valid", resp_valid, 1'b0);
		foreach (rows[i]) begin
			if (rows[i].usr_reset) pulse_user_reset();
			else if (rows[i].sof) apply_sof();
			else perform_access(rows[i]);
		end
		finish_run();
	end

endmodule

//--- tb/tb_clock_gen.sv
//----------------------------------------------------------
// clock and reset source for the testbench
// reset drops by a non-blocking write on a rising edge
//----------------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0; // dut sees it low from the next edge
	end

endmodule

//--- hw/sys_glue_top.sv
//----------------------------------------------------------
// system glue top level built from instances and wires only
// sof must come from the video timing as a 1-cycle pulse
// accesses are refused until the reset sequence ends
//----------------------------------------------------------
`timescale 1ns/1ps

module sys_glue_top (
	input  logic clk,
	input  logic reset,
	input  logic usr_reset,
	input  logic sof,
	// cpu request
	input  logic req_valid,
	output logic req_ready,
	input  sys_glue_pkg::cpu_addr_t req_addr,
	input  logic req_write,
	input  sys_glue_pkg::data_word_t req_wdata,
	// data sources
	input  sys_glue_pkg::data_word_t ext_rdata,
	input  logic [63:0] rtc,
	// cpu response
	output logic resp_valid,
	input  logic resp_ready,
	output sys_glue_pkg::region_t resp_region,
	output sys_glue_pkg::data_word_t resp_data,
	// interrupts
	input  sys_glue_pkg::ipl_t ipl_n_in,
	input  logic freeze,
	output sys_glue_pkg::ipl_t ipl_n_out,
	// reset status
	output logic sys_reset,
	output logic cpu_reset_n
);

	import sys_glue_pkg::*;

	logic count_clear;
	logic count_en;
	logic count_done;
	logic ovl; // kickstart overlay
	region_t region; // decode of the live request

	//----------------------------------------------------------
	// reset path
	//----------------------------------------------------------
	frame_counter frame_counter_i (
		.clk         (clk),
		.reset       (reset),
		.count_clear (count_clear),
		.count_en    (count_en),
		.sof         (sof),
		.count_done  (count_done)
	);

	reset_sequencer reset_sequencer_i (
		.clk         (clk),
		.reset       (reset),
		.usr_reset   (usr_reset),
		.count_done  (count_done),
		.count_clear (count_clear),
		.count_en    (count_en),
		.sys_reset   (sys_reset),
		.cpu_reset_n (cpu_reset_n)
	);

	//----------------------------------------------------------
	// cpu bus
	//----------------------------------------------------------
	address_decoder address_decoder_i (
		.addr   (req_addr),
		.ovl    (ovl),
		.region (region)
	);

	cpu_bus_port cpu_bus_port_i (
		.clk         (clk),
		.reset       (reset),
		.sys_reset   (sys_reset),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.req_addr    (req_addr),
		.req_write   (req_write),
		.req_wdata   (req_wdata),
		.region      (region),
		.ovl         (ovl),
		.ext_rdata   (ext_rdata),
		.rtc         (rtc),
		.resp_valid  (resp_valid),
		.resp_ready  (resp_ready),
		.resp_region (resp_region),
		.resp_data   (resp_data),
		.ipl_n_in    (ipl_n_in),
		.freeze      (freeze),
		.ipl_n_out   (ipl_n_out)
	);

endmodule

//--- hw/cpu_bus_port.sv
//----------------------------------------------------------
// cpu access port, valid/ready on request and response
// one access in flight, response one cycle after accept
// read data sampled at accept, writes answer with zero
// no access is taken while sys_reset is high
//----------------------------------------------------------
`timescale 1ns/1ps
`include "sys_glue_macros.svh"

module cpu_bus_port (
	input  logic clk,
	input  logic reset,
	input  logic sys_reset,
	// request channel
	input  logic req_valid,
	output logic req_ready,
	input  sys_glue_pkg::cpu_addr_t req_addr,
	input  logic req_write,
	input  sys_glue_pkg::data_word_t req_wdata,
	// decode and data sources
	input  sys_glue_pkg::region_t region, // decode of req_addr
	output logic ovl,
	input  sys_glue_pkg::data_word_t ext_rdata,
	input  logic [63:0] rtc, // 16 nibbles of clock state
	// response channel
	output logic resp_valid,
	input  logic resp_ready,
	output sys_glue_pkg::region_t resp_region,
	output sys_glue_pkg::data_word_t resp_data,
	// interrupts
	input  sys_glue_pkg::ipl_t ipl_n_in, // from sound chip
	input  logic freeze, // cartridge freeze button
	output sys_glue_pkg::ipl_t ipl_n_out
);

	import sys_glue_pkg::*;

	logic accept;
	data_word_t rtc_rdata;

	//----------------------------------------------------------
	// handshake
	//----------------------------------------------------------
	assign req_ready = !sys_reset && (!resp_valid || resp_ready); // slot free or draining
	assign accept    = req_valid && req_ready;

	// addressed nibble, address bits 5..2 pick it
	assign rtc_rdata = {{(`DATA_W-4){1'b0}}, rtc[{req_addr[4:1], 2'b00} +: 4]};

	always_ff @(posedge clk) begin
		if (reset) begin
			resp_valid <= 1'b0;
		end else if (accept) begin
			resp_valid <= 1'b1;
		end else if (resp_ready) begin
			resp_valid <= 1'b0; // consumed
		end
	end

	// response payload
	always_ff @(posedge clk) begin
		if (accept) begin
			resp_region <= region;
			if (req_write) resp_data <= '0;
			else if (region == REGION_RTC) resp_data <= rtc_rdata;
			else resp_data <= ext_rdata;
		end
	end

	// overlay: set through reset, first cia a write drops it
	always_ff @(posedge clk) begin
		if (reset || sys_reset) begin
			ovl <= 1'b1;
		end else if (accept && req_write && region == REGION_CIA_A) begin
			ovl <= 1'b0;
		end
	end

	// level 7 on freeze overrides the sound chip request
	always_ff @(posedge clk) begin
		if (reset) ipl_n_out <= 3'b111; // no interrupt
		else ipl_n_out <= freeze ? 3'b000 : ipl_n_in;
	end

	//----------------------------------------------------------
	// checks
	//----------------------------------------------------------
	resp_held: assert property (
		@(posedge clk) disable iff (reset)
		(resp_valid && !resp_ready) |=>
			resp_valid && $stable(resp_region) && $stable(resp_data)
	) else $error("response changed while stalled");

	// cpu side must present real data with a write
	wdata_known: assert property (
		@(posedge clk) disable iff (reset)
		(accept && req_write) |-> !$isunknown(req_wdata)
	) else $error("write accepted with unknown data");

endmodule

//--- hw/address_decoder.sv
//----------------------------------------------------------
// cpu address decode, purely combinational
// only the bank byte (address bits 23..16) is looked at
// overlay maps banks 00..OVL_TOP_BANK onto kickstart rom
//----------------------------------------------------------
`timescale 1ns/1ps
`include "sys_glue_macros.svh"

module address_decoder (
	input  sys_glue_pkg::cpu_addr_t addr, // word address 23..1
	input  logic ovl, // kickstart overlay active
	output sys_glue_pkg::region_t region
);

	import sys_glue_pkg::*;

	logic [7:0] bank;

	assign bank = addr[`ADDR_W-1 -: 8]; // address bits 23..16

	//----------------------------------------------------------
	// bank map
	//----------------------------------------------------------
	always_comb begin
		if (ovl && bank <= `OVL_TOP_BANK) begin
			region = REGION_KICK; // rom shadow at zero after reset
		end else if (bank <= `CHIP_TOP_BANK) begin
			region = REGION_CHIP;
		end else if (bank == `CIA_A_BANK) begin
			region = REGION_CIA_A;
		end else if (bank == `RTC_BANK) begin
			region = REGION_RTC;
		end else if (bank >= `KICK_BASE_BANK) begin
			region = REGION_KICK; // f8..ff
		end else begin
			// slow ram, custom regs, cia b etc. are not
			// part of this core
			region = REGION_NONE;
		end
	end

endmodule

//--- hw/reset_sequencer.sv
//----------------------------------------------------------
// system reset sequencing
// reset or usr_reset restarts the frame wait from HOLD
// sys_reset drops after RESET_FRAMES sof pulses
// cpu_reset_n follows two cycles behind, never early
//----------------------------------------------------------
`timescale 1ns/1ps

module reset_sequencer (
	input  logic clk,
	input  logic reset,
	input  logic usr_reset, // user reset, e.g. from osd
	input  logic count_done, // frame counter at limit
	output logic count_clear,
	output logic count_en,
	output logic sys_reset, // glue held in reset
	output logic cpu_reset_n // to cpu, active low
);

	typedef enum logic [1:0] {
		HOLD,
		COUNT,
		RUN
	} seq_state_t;

	seq_state_t state, state_next;
	logic sync_q; // first synchronizer stage

	//----------------------------------------------------------
	// state machine
	//----------------------------------------------------------
	always_comb begin
		state_next = state;
		case (state)
			HOLD:  state_next = COUNT; // one cycle to clear the counter
			COUNT: if (count_done) state_next = RUN;
			RUN:   state_next = RUN;
			default: state_next = HOLD;
		endcase
		if (usr_reset) state_next = HOLD; // user reset wins anywhere
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= HOLD;
			sys_reset <= 1'b1;
		end else begin
			state     <= state_next;
			sys_reset <= (state_next != RUN); // registered copy of state
		end
	end

	assign count_clear = (state == HOLD);
	assign count_en    = (state == COUNT);

	// two flops from the inverse of sys_reset
	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q      <= 1'b0;
			cpu_reset_n <= 1'b0;
		end else begin
			sync_q      <= ~sys_reset;
			cpu_reset_n <= sync_q;
		end
	end

	// glue stays in reset outside RUN
	hold_outside_run: assert property (
		@(posedge clk) disable iff (reset)
		(state != RUN) |-> sys_reset
	) else $error("sys_reset low outside RUN");

	// cpu leaves reset two cycles after the glue, unless reset again
	cpu_release_delay: assert property (
		@(posedge clk) disable iff (reset)
		$fell(sys_reset) |-> !cpu_reset_n ##2 (cpu_reset_n || sys_reset)
	) else $error("cpu_reset_n release timing");

endmodule

//--- hw/frame_counter.sv
//----------------------------------------------------------
// counts start-of-frame pulses for the reset sequencer
// saturates at RESET_FRAMES, count_done holds until cleared
// sof is expected as a one-cycle pulse
//----------------------------------------------------------
`timescale 1ns/1ps
`include "sys_glue_macros.svh"

module frame_counter (
	input  logic clk,
	input  logic reset,
	input  logic count_clear, // sync clear, seen next cycle
	input  logic count_en, // count sof only while set
	input  logic sof, // start of video frame
	output logic count_done // count reached RESET_FRAMES
);

	localparam int CNT_W = $clog2(`RESET_FRAMES + 1);

	logic [CNT_W-1:0] count;

	assign count_done = (count == CNT_W'(`RESET_FRAMES));

	always_ff @(posedge clk) begin
		if (reset || count_clear) begin
			count <= '0;
		end else if (count_en && sof && !count_done) begin
			count <= count + 1'b1; // stops at the limit
		end
	end

	// counter must never run past the frame limit
	count_in_range: assert property (
		@(posedge clk) disable iff (reset)
		count <= CNT_W'(`RESET_FRAMES)
	) else $error("frame count above limit");

endmodule

//--- hw/sys_glue_pkg.sv
//----------------------------------------------------------
// types shared by the glue modules
// region_t encoding is fixed, testbench compares raw values
// widths come from the macro header
//----------------------------------------------------------
`include "sys_glue_macros.svh"

package sys_glue_pkg;

	// cpu word address, index 0 is address bit 1
	typedef logic [`ADDR_W-1:0] cpu_addr_t;

	// one cpu data word
	typedef logic [`DATA_W-1:0] data_word_t;

	// decoded target of a cpu access
	typedef enum logic [2:0] {
		REGION_NONE  = 3'd0, // unmapped, ext data returned
		REGION_CHIP  = 3'd1, // chip ram
		REGION_KICK  = 3'd2, // kickstart rom or overlay
		REGION_CIA_A = 3'd3, // cia a registers
		REGION_RTC   = 3'd4 // real-time clock
	} region_t;

	// interrupt priority level, active low as on the 68k pins
	typedef logic [2:0] ipl_t;

endpackage

//--- hw/sys_glue_macros.svh
//----------------------------------------------------------
// shared constants for the system glue
// bank = cpu address bits 23..16, word address drops bit 0
// all bank values are 8-bit compares against that byte
//----------------------------------------------------------
`ifndef SYS_GLUE_MACROS_SVH
`define SYS_GLUE_MACROS_SVH

// bus widths
`define ADDR_W 23 // word address, bits 23..1
`define DATA_W 16 // cpu data word

// reset sequencing
`define RESET_FRAMES 4 // sof pulses held in reset

//----------------------------------------------------------
// memory map banks
//----------------------------------------------------------
`define CHIP_TOP_BANK 8'h1F // last chip ram bank
`define OVL_TOP_BANK 8'h07 // rom shadowed up to here while overlay set
`define CIA_A_BANK 8'hBF // cia a, any write clears overlay
`define RTC_BANK 8'hDC // real-time clock nibbles
`define KICK_BASE_BANK 8'hF8 // kickstart rom up to bank ff

`endif
